/* source/udp_rx_pkg.sv */
// UDP/IP receive engine
// Shared types and sizes

package udp_rx_pkg;

    // ============================================================
    // Sizes and protocol constants
    // ============================================================
    localparam int BEAT_BYTES          = 32;
    // Payload bytes carried in the second beat
    localparam int FIRST_PAYLOAD_BYTES = 22;
    localparam int MAX_PAYLOAD_BYTES   = 54;
    localparam int UDP_HDR_BYTES       = 8;
    localparam int IP_VERSION_4        = 4;
    localparam int IP_PROTO_UDP        = 17;
    // Four-entry packet buffer
    localparam int FIFO_LOG_DEPTH      = 2;
    localparam int COUNTER_WIDTH       = 32;

    // ============================================================
    // Header types, wire order
    // ============================================================
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;

    localparam mac_addr_t BROADCAST_MAC = '1;

    // 14 bytes
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // 20 bytes, no options
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] frag_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] hdr_checksum;
        ipv4_addr_t  src_ip;
        ipv4_addr_t  dest_ip;
    } ip_hdr_t;

    // 8 bytes, length includes the header
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // ============================================================
    // Stream, record and event types
    // ============================================================
    typedef struct packed {
        logic [BEAT_BYTES*8-1:0] data;
        logic                    valid;
        logic                    sop;
        logic                    eop;
        // Unused low bytes on the eop beat
        logic [4:0]              empty;
    } rx_beat_t;

    // Payload byte 0 sits in the top byte
    typedef struct packed {
        eth_hdr_t                       eth;
        ip_hdr_t                        ip;
        udp_hdr_t                       udp;
        logic [MAX_PAYLOAD_BYTES*8-1:0] payload;
        logic [15:0]                    byte_count;
        logic                           oversize;
    } rx_packet_t;

    typedef struct packed {
        ipv4_addr_t                     src_ip;
        logic [15:0]                    src_port;
        logic [15:0]                    dest_port;
        logic [MAX_PAYLOAD_BYTES*8-1:0] payload;
        logic [15:0]                    length;
    } rx_delivery_t;

    // One bit per drop cause
    typedef struct packed {
        logic dest_mac;
        logic dest_ip;
        logic protocol;
        logic version;
        logic length;
        logic overflow;
    } drop_event_t;

    typedef enum logic [2:0] {
        total_drops   = 3'd0,
        fifo_overflow = 3'd1,
        dest_mac_err  = 3'd2,
        dest_ip_err   = 3'd3,
        protocol_err  = 3'd4,
        version_err   = 3'd5,
        length_err    = 3'd6
    } counter_id_t;

    typedef enum logic [1:0] {
        idle,
        header_tail,
        payload,
        flush
    } parser_state_t;

endpackage

/* source/rx_frame_parser.sv */
// Receive frame parser
// One packet record per frame

`timescale 1ns/10ps

module rx_frame_parser
    import udp_rx_pkg::*;
(
    input  logic       rx_clk_in,
    input  logic       rx_reset_in,
    input  rx_beat_t   rx_beat,
    output logic       pkt_push,
    output rx_packet_t pkt_record,
    output logic       short_frame
);

    parser_state_t state, state_next;

    // Beat qualifiers
    logic start_frame;
    logic take_tail;
    logic take_pay;
    logic take_flush;
    logic frame_done;
    logic frame_short;

    // Eop beat byte masking
    logic [BEAT_BYTES*8-1:0] beat_mask;
    logic [BEAT_BYTES*8-1:0] beat_data;
    logic [15:0]             eop_empty;

    // ============================================================
    // Beat decode and next state
    // ============================================================
    always_comb begin
        // A sop beat restarts in any state
        start_frame = rx_beat.valid && rx_beat.sop;
        take_tail   = rx_beat.valid && !rx_beat.sop && (state == header_tail);
        take_pay    = rx_beat.valid && !rx_beat.sop && (state == payload);
        take_flush  = rx_beat.valid && !rx_beat.sop && (state == flush);
        frame_done  = (take_tail || take_pay || take_flush) && rx_beat.eop;
        // Frame ending on beat 0 carries no UDP header
        frame_short = start_frame && rx_beat.eop;

        state_next = state;
        if (start_frame) begin
            state_next = rx_beat.eop ? idle : header_tail;
        end else if (frame_done) begin
            state_next = idle;
        end else if (take_tail) begin
            state_next = payload;
        end else if (take_pay) begin
            // Fourth beat on its way
            state_next = flush;
        end
    end

    // Zero the unused low bytes of the eop beat
    always_comb begin
        if (rx_beat.eop) begin
            beat_mask = {BEAT_BYTES*8{1'b1}} << {rx_beat.empty, 3'b000};
            eop_empty = {11'd0, rx_beat.empty};
        end else begin
            beat_mask = {BEAT_BYTES*8{1'b1}};
            eop_empty = 16'd0;
        end
        beat_data = rx_beat.data & beat_mask;
    end

    // ============================================================
    // State and strobes
    // ============================================================
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            state       <= idle;
            pkt_push    <= 1'b0;
            short_frame <= 1'b0;
        end else begin
            state       <= state_next;
            pkt_push    <= frame_done;
            short_frame <= frame_short;
        end
    end

    // ============================================================
    // Record capture
    // ============================================================
    always_ff @(posedge rx_clk_in) begin
        // Beat 0: eth header and top 18 IP bytes
        if (start_frame) begin
            pkt_record.eth         <= rx_beat.data[255:144];
            pkt_record.ip[159:16]  <= rx_beat.data[143:0];
        end

        // Beat 1: IP tail, UDP header, payload bytes 0 to 21
        if (take_tail) begin
            pkt_record.ip[15:0]    <= rx_beat.data[255:240];
            pkt_record.udp         <= rx_beat.data[239:176];
            pkt_record.payload     <= {beat_data[175:0], 256'd0};
            pkt_record.byte_count  <= 16'(FIRST_PAYLOAD_BYTES) - eop_empty;
            pkt_record.oversize    <= 1'b0;
        end

        // Beat 2: payload bytes 22 to 53
        if (take_pay) begin
            pkt_record.payload[255:0] <= beat_data;
            pkt_record.byte_count     <= pkt_record.byte_count + 16'(BEAT_BYTES) - eop_empty;
        end

        // Anything past beat 2 makes the frame oversize
        if (take_flush) begin
            pkt_record.oversize <= 1'b1;
        end
    end

    // Stream protocol on the input
    sop_needs_valid: assert property (
        @(posedge rx_clk_in) disable iff (rx_reset_in)
        rx_beat.sop |-> rx_beat.valid
    ) else $error("sop seen without valid");

endmodule

/* source/rx_packet_fifo.sv */
// Packet record FIFO

`timescale 1ns/10ps

module rx_packet_fifo
    import udp_rx_pkg::*;
#(
    parameter int LOG_DEPTH = FIFO_LOG_DEPTH
) (
    input  logic       rx_clk_in,
    input  logic       rx_reset_in,
    input  logic       push,
    input  logic       pop,
    input  rx_packet_t push_data,
    output rx_packet_t pop_data,
    output logic       empty,
    output logic       overflow
);

    localparam int DEPTH = 2 ** LOG_DEPTH;

    rx_packet_t mem [DEPTH];

    // Extra msb tells full from empty
    logic [LOG_DEPTH:0] wr_ptr;
    logic [LOG_DEPTH:0] rd_ptr;
    logic               full;

    always_comb begin
        empty    = (wr_ptr == rd_ptr);
        full     = (wr_ptr[LOG_DEPTH] != rd_ptr[LOG_DEPTH])
                && (wr_ptr[LOG_DEPTH-1:0] == rd_ptr[LOG_DEPTH-1:0]);
        // Push into a full buffer is lost
        overflow = push && full;
    end

    // Pointers
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage and registered read port
    always_ff @(posedge rx_clk_in) begin
        if (push && !full)
            mem[wr_ptr[LOG_DEPTH-1:0]] <= push_data;
        if (pop && !empty)
            pop_data <= mem[rd_ptr[LOG_DEPTH-1:0]];
    end

    // Consumer must respect empty
    no_pop_when_empty: assert property (
        @(posedge rx_clk_in) disable iff (rx_reset_in)
        pop |-> !empty
    ) else $error("pop on empty packet FIFO");

endmodule

/* source/udp_packet_filter.sv */
// Address and protocol filter
// Drop decision and delivery strobe

`timescale 1ns/10ps

module udp_packet_filter
    import udp_rx_pkg::*;
(
    input  logic         rx_clk_in,
    input  logic         rx_reset_in,
    input  logic         deliver_hold,
    input  mac_addr_t    host_mac,
    input  ipv4_addr_t   host_ip,
    input  logic         fifo_empty,
    input  rx_packet_t   pop_data,
    output logic         pop,
    output logic         app_valid,
    output rx_delivery_t app_packet,
    output drop_event_t  drop_evt
);

    // Record due on pop_data this cycle
    logic        wait_q;
    drop_event_t fail;
    logic        any_fail;

    // One pop in flight at a time
    always_comb begin
        pop = !fifo_empty && !deliver_hold && !wait_q;
    end

    // ============================================================
    // Checks on the popped record
    // ============================================================
    always_comb begin
        // Unicast to us or broadcast
        fail.dest_mac = (pop_data.eth.dest_mac != host_mac)
                     && (pop_data.eth.dest_mac != BROADCAST_MAC);
        fail.dest_ip  = (pop_data.ip.dest_ip != host_ip);
        fail.protocol = (pop_data.ip.protocol != 8'(IP_PROTO_UDP));
        fail.version  = (pop_data.ip.version != 4'(IP_VERSION_4));
        // UDP length covers its own header
        fail.length   = pop_data.oversize
                     || ((pop_data.udp.length - 16'(UDP_HDR_BYTES)) != pop_data.byte_count);
        // Overflow drops are reported by the FIFO
        fail.overflow = 1'b0;
        any_fail      = |fail;
    end

    // ============================================================
    // Registered verdict
    // ============================================================
    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            wait_q    <= 1'b0;
            app_valid <= 1'b0;
            drop_evt  <= '0;
        end else begin
            wait_q    <= pop;
            app_valid <= wait_q && !any_fail;
            if (wait_q)
                drop_evt <= fail;
            else
                drop_evt <= '0;
        end
    end

    // Delivery fields, qualified by app_valid
    always_ff @(posedge rx_clk_in) begin
        if (wait_q) begin
            app_packet.src_ip    <= pop_data.ip.src_ip;
            app_packet.src_port  <= pop_data.udp.src_port;
            app_packet.dest_port <= pop_data.udp.dest_port;
            app_packet.payload   <= pop_data.payload;
            app_packet.length    <= pop_data.byte_count;
        end
    end

    // A packet is either delivered or dropped
    deliver_or_drop: assert property (
        @(posedge rx_clk_in) disable iff (rx_reset_in)
        app_valid |-> (drop_evt == '0)
    ) else $error("delivery and drop in the same cycle");

endmodule

/* source/rx_drop_counters.sv */
// Drop counter bank

`timescale 1ns/10ps

module rx_drop_counters
    import udp_rx_pkg::*;
(
    input  logic                     rx_clk_in,
    input  logic                     rx_reset_in,
    input  drop_event_t              drop_evt,
    input  logic                     overflow,
    input  logic                     short_frame,
    input  logic                     counter_rd,
    input  counter_id_t              counter_sel,
    output logic                     counter_valid,
    output logic [COUNTER_WIDTH-1:0] counter_value
);

    localparam int NUM_COUNTERS = 7;

    logic [COUNTER_WIDTH-1:0] cnt     [NUM_COUNTERS];
    // Up to three drops can land in one cycle
    logic [1:0]               cnt_inc [NUM_COUNTERS];
    logic                     filter_drop;
    logic                     ovf_hit;

    always_comb begin
        filter_drop = drop_evt.dest_mac || drop_evt.dest_ip || drop_evt.protocol
                   || drop_evt.version || drop_evt.length;
        ovf_hit     = overflow || drop_evt.overflow;

        // One per dropped packet, whatever the cause
        cnt_inc[total_drops]   = {1'b0, filter_drop} + {1'b0, ovf_hit} + {1'b0, short_frame};
        cnt_inc[fifo_overflow] = {1'b0, ovf_hit};
        cnt_inc[dest_mac_err]  = {1'b0, drop_evt.dest_mac};
        cnt_inc[dest_ip_err]   = {1'b0, drop_evt.dest_ip};
        cnt_inc[protocol_err]  = {1'b0, drop_evt.protocol};
        cnt_inc[version_err]   = {1'b0, drop_evt.version};
        // Short frames count as length errors
        cnt_inc[length_err]    = {1'b0, drop_evt.length} + {1'b0, short_frame};
    end

    always_ff @(posedge rx_clk_in or posedge rx_reset_in) begin
        if (rx_reset_in) begin
            for (int i = 0; i < NUM_COUNTERS; i++)
                cnt[i] <= '0;
            counter_valid <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_COUNTERS; i++)
                cnt[i] <= cnt[i] + COUNTER_WIDTH'(cnt_inc[i]);
            counter_valid <= counter_rd;
        end
    end

    // Read sees counts from before this cycle
    always_ff @(posedge rx_clk_in) begin
        if (counter_rd) begin
            case (counter_sel)
                total_drops, fifo_overflow, dest_mac_err, dest_ip_err,
                protocol_err, version_err, length_err:
                    counter_value <= cnt[counter_sel];
                default:
                    counter_value <= '0;
            endcase
        end
    end

endmodule

/* source/udp_rx_top.sv */
// UDP/IP receive engine top

`timescale 1ns/10ps

module udp_rx_top
    import udp_rx_pkg::*;
(
    input  logic                     rx_clk_in,
    input  logic                     rx_reset_in,
    input  rx_beat_t                 rx_beat,
    input  mac_addr_t                host_mac,
    input  ipv4_addr_t               host_ip,
    input  logic                     deliver_hold,
    input  logic                     counter_rd,
    input  counter_id_t              counter_sel,
    output logic                     app_valid,
    output rx_delivery_t             app_packet,
    output logic                     counter_valid,
    output logic [COUNTER_WIDTH-1:0] counter_value
);

    // Parser to FIFO
    logic        pkt_push;
    rx_packet_t  pkt_record;
    logic        short_frame;
    // FIFO to filter
    logic        fifo_empty;
    rx_packet_t  pop_data;
    logic        pop;
    // Drop reporting
    logic        fifo_ovf;
    drop_event_t drop_evt;

    rx_frame_parser rx_frame_parser_i (
        .rx_clk_in   (rx_clk_in),
        .rx_reset_in (rx_reset_in),
        .rx_beat     (rx_beat),
        .pkt_push    (pkt_push),
        .pkt_record  (pkt_record),
        .short_frame (short_frame)
    );

    rx_packet_fifo #(
        .LOG_DEPTH (FIFO_LOG_DEPTH)
    ) rx_packet_fifo_i (
        .rx_clk_in   (rx_clk_in),
        .rx_reset_in (rx_reset_in),
        .push        (pkt_push),
        .pop         (pop),
        .push_data   (pkt_record),
        .pop_data    (pop_data),
        .empty       (fifo_empty),
        .overflow    (fifo_ovf)
    );

    udp_packet_filter udp_packet_filter_i (
        .rx_clk_in    (rx_clk_in),
        .rx_reset_in  (rx_reset_in),
        .deliver_hold (deliver_hold),
        .host_mac     (host_mac),
        .host_ip      (host_ip),
        .fifo_empty   (fifo_empty),
        .pop_data     (pop_data),
        .pop          (pop),
        .app_valid    (app_valid),
        .app_packet   (app_packet),
        .drop_evt     (drop_evt)
    );

    rx_drop_counters rx_drop_counters_i (
        .rx_clk_in     (rx_clk_in),
        .rx_reset_in   (rx_reset_in),
        .drop_evt      (drop_evt),
        .overflow      (fifo_ovf),
        .short_frame   (short_frame),
        .counter_rd    (counter_rd),
        .counter_sel   (counter_sel),
        .counter_valid (counter_valid),
        .counter_value (counter_value)
    );

endmodule

/* test/udp_rx_model.svh */
// UDP receive reference model
// Frame builder, LFSR and filter reference

`ifndef UDP_RX_MODEL_SVH
`define UDP_RX_MODEL_SVH

// One frame before it is cut into beats
typedef struct packed {
    eth_hdr_t                       eth;
    ip_hdr_t                        ip;
    udp_hdr_t                       udp;
    logic [MAX_PAYLOAD_BYTES*8-1:0] payload;
    logic [7:0]                     pay_len;
    logic                           extra_beat;
} test_frame_t;

logic [31:0] lfsr_state;
rx_beat_t    beat_q[$];

// Galois LFSR, taps 32 22 2 1, one step per bit taken
function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[62:0], lfsr_state[0]};
        if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        else
            lfsr_state = lfsr_state >> 1;
    end
    return r;
endfunction

// Good UDP frame to the host, random fields and length
function automatic test_frame_t make_frame(input logic bcast, input mac_addr_t hmac,
                                           input ipv4_addr_t hip);
    test_frame_t f;
    int          len;
    len = int'(rand_bits(6)) % MAX_PAYLOAD_BYTES + 1;
    f = '0;
    f.eth.dest_mac = bcast ? BROADCAST_MAC : hmac;
    f.eth.src_mac = 48'(rand_bits(48));
    f.eth.eth_type = 16'h0800;
    f.ip.version = 4'(IP_VERSION_4);
    f.ip.ihl = 4'd5;
    f.ip.total_length = 16'(20 + UDP_HDR_BYTES + len);
    f.ip.identification = 16'(rand_bits(16));
    f.ip.ttl = 8'd64;
    f.ip.protocol = 8'(IP_PROTO_UDP);
    f.ip.hdr_checksum = 16'(rand_bits(16));
    f.ip.src_ip = 32'(rand_bits(32));
    f.ip.dest_ip = hip;
    f.udp.src_port = 16'(rand_bits(16));
    f.udp.dest_port = 16'(rand_bits(16));
    f.udp.length = 16'(UDP_HDR_BYTES + len);
    f.udp.checksum = 16'(rand_bits(16));
    // Bytes past len stay random, the DUT must zero them
    for (int i = 0; i < MAX_PAYLOAD_BYTES; i++)
        f.payload[8*i +: 8] = 8'(rand_bits(8));
    f.pay_len = 8'(len);
    return f;
endfunction

// ============================================================
// Frame to beats, header bytes at the top of each beat
// ============================================================
task automatic build_beats(input test_frame_t f);
    rx_beat_t b;
    int       len;
    len = int'(f.pay_len);
    beat_q.delete();
    b = '0;
    b.valid = 1'b1;
    b.sop = 1'b1;
    b.data = {f.eth, f.ip[159:16]};
    beat_q.push_back(b);
    // IP tail, UDP header, payload 0 to 21
    b.sop = 1'b0;
    b.data = {f.ip[15:0], f.udp, f.payload[431:256]};
    b.eop = (len <= FIRST_PAYLOAD_BYTES) && !f.extra_beat;
    b.empty = b.eop ? 5'(FIRST_PAYLOAD_BYTES - len) : 5'd0;
    beat_q.push_back(b);
    if (!b.eop) begin
        b.data = f.payload[255:0];
        b.eop = !f.extra_beat;
        b.empty = b.eop ? 5'(MAX_PAYLOAD_BYTES - len) : 5'd0;
        beat_q.push_back(b);
    end
    // Fourth beat makes the frame oversize
    if (f.extra_beat) begin
        b.data = {4{rand_bits(64)}};
        b.eop = 1'b1;
        b.empty = 5'd0;
        beat_q.push_back(b);
    end
endtask

// Expected verdict, delivery record when no cause is set
function automatic drop_event_t ref_filter(input test_frame_t f, input mac_addr_t hmac,
                                           input ipv4_addr_t hip, output rx_delivery_t d);
    drop_event_t                    e;
    logic [MAX_PAYLOAD_BYTES*8-1:0] keep;
    e = '0;
    e.dest_mac = (f.eth.dest_mac != hmac) && (f.eth.dest_mac != BROADCAST_MAC);
    e.dest_ip = (f.ip.dest_ip != hip);
    e.protocol = (f.ip.protocol != 8'(IP_PROTO_UDP));
    e.version = (f.ip.version != 4'(IP_VERSION_4));
    e.length = f.extra_beat || (int'(f.udp.length) - UDP_HDR_BYTES != int'(f.pay_len));
    // Only the first pay_len bytes survive
    keep = ~({MAX_PAYLOAD_BYTES*8{1'b1}} >> (8 * int'(f.pay_len)));
    d.src_ip = f.ip.src_ip;
    d.src_port = f.udp.src_port;
    d.dest_port = f.udp.dest_port;
    d.payload = f.payload & keep;
    d.length = 16'(f.pay_len);
    return e;
endfunction

`endif

/* test/udp_rx_tb.sv */
// UDP receive engine testbench

`timescale 1ns/10ps

module udp_rx_tb
    import udp_rx_pkg::*;
();

    logic                     rx_clk_in;
    logic                     rx_reset_in;
    rx_beat_t                 rx_beat;
    mac_addr_t                host_mac;
    ipv4_addr_t               host_ip;
    logic                     deliver_hold;
    logic                     counter_rd;
    counter_id_t              counter_sel;
    logic                     app_valid;
    rx_delivery_t             app_packet;
    logic                     counter_valid;
    logic [COUNTER_WIDTH-1:0] counter_value;

    // Expected deliveries in order, expected counter values
    rx_delivery_t             exp_q[$];
    logic [COUNTER_WIDTH-1:0] exp_cnt[7];

    `include "udp_rx_model.svh"

    udp_rx_top udp_rx_top_i (
        .rx_clk_in     (rx_clk_in),
        .rx_reset_in   (rx_reset_in),
        .rx_beat       (rx_beat),
        .host_mac      (host_mac),
        .host_ip       (host_ip),
        .deliver_hold  (deliver_hold),
        .counter_rd    (counter_rd),
        .counter_sel   (counter_sel),
        .app_valid     (app_valid),
        .app_packet    (app_packet),
        .counter_valid (counter_valid),
        .counter_value (counter_value)
    );

    initial begin
        rx_clk_in = 1'b0;
        forever #4 rx_clk_in = ~rx_clk_in;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at the first failed check");
    endtask

    // ============================================================
    // Compare tasks and compare process
    // ============================================================
    task automatic compare_delivery(input string name, input rx_delivery_t got,
                                    input rx_delivery_t exp);
        if (got !== exp)
            fail_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic compare_counter(input string name, input logic [COUNTER_WIDTH-1:0] got,
                                   input logic [COUNTER_WIDTH-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("error at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    // Outputs sampled on the falling edge
    always @(negedge rx_clk_in) begin
        if (!rx_reset_in && app_valid) begin
            if (exp_q.size() == 0)
                fail_run("app_valid pulsed while no delivery was expected");
            else
                compare_delivery("app_packet", app_packet, exp_q.pop_front());
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic send_beats();
        foreach (beat_q[i]) begin
            @(posedge rx_clk_in);
            rx_beat <= beat_q[i];
        end
        @(posedge rx_clk_in);
        rx_beat <= '0;
    endtask

    // Lost frames hit a full FIFO
    task automatic send_frame(input test_frame_t f, input logic lost);
        drop_event_t  e;
        rx_delivery_t d;
        e = ref_filter(f, host_mac, host_ip, d);
        if (lost) begin
            exp_cnt[fifo_overflow]++;
            exp_cnt[total_drops]++;
        end else if (e == '0) begin
            exp_q.push_back(d);
        end else begin
            exp_cnt[total_drops]++;
            exp_cnt[dest_mac_err] += COUNTER_WIDTH'(e.dest_mac);
            exp_cnt[dest_ip_err] += COUNTER_WIDTH'(e.dest_ip);
            exp_cnt[protocol_err] += COUNTER_WIDTH'(e.protocol);
            exp_cnt[version_err] += COUNTER_WIDTH'(e.version);
            exp_cnt[length_err] += COUNTER_WIDTH'(e.length);
        end
        build_beats(f);
        send_beats();
    endtask

    // Single beat frame, no UDP header at all
    task automatic send_short();
        rx_beat_t b;
        b = '0;
        b.valid = 1'b1;
        b.sop = 1'b1;
        b.eop = 1'b1;
        b.data = {4{rand_bits(64)}};
        beat_q.delete();
        beat_q.push_back(b);
        exp_cnt[total_drops]++;
        exp_cnt[length_err]++;
        send_beats();
    endtask

    // counter_valid must follow counter_rd by exactly one cycle
    task automatic read_counter(input counter_id_t sel, output logic [COUNTER_WIDTH-1:0] val);
        @(posedge rx_clk_in);
        counter_rd <= 1'b1;
        counter_sel <= sel;
        @(negedge rx_clk_in);
        if (counter_valid)
            fail_run("counter_valid rose in the same cycle as counter_rd");
        @(posedge rx_clk_in);
        counter_rd <= 1'b0;
        @(negedge rx_clk_in);
        if (!counter_valid)
            fail_run("counter_valid did not pulse one cycle after counter_rd");
        val = counter_value;
    endtask

    task automatic wait_deliveries();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            n++;
            if (n > 2000)
                fail_run("timeout waiting for the expected deliveries");
            else
                @(posedge rx_clk_in);
        end
    endtask

    // Poll total_drops until every expected drop has landed
    task automatic wait_drops();
        logic [COUNTER_WIDTH-1:0] v;
        int                       polls;
        polls = 0;
        read_counter(total_drops, v);
        while (v < exp_cnt[total_drops]) begin
            polls++;
            if (polls > 200)
                fail_run("timeout waiting for the drop counters to settle");
            else
                read_counter(total_drops, v);
        end
    endtask

    task automatic check_counters();
        logic [COUNTER_WIDTH-1:0] v;
        counter_id_t              cid;
        wait_deliveries();
        wait_drops();
        for (int i = 0; i < 7; i++) begin
            cid = counter_id_t'(i);
            read_counter(cid, v);
            compare_counter($sformatf("counter_value[%s]", cid.name()), v, exp_cnt[i]);
        end
        // Select past the last counter
        read_counter(counter_id_t'(3'd7), v);
        compare_counter("counter_value[sel 7]", v, '0);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        test_frame_t f;
        lfsr_state = 32'hed6c_d462;
        rx_reset_in = 1'b1;
        rx_beat = '0;
        host_mac = 48'h02_5e_10_20_30_41;
        host_ip = 32'hc0a8_0a05;
        deliver_hold = 1'b0;
        counter_rd = 1'b0;
        counter_sel = total_drops;
        foreach (exp_cnt[i])
            exp_cnt[i] = '0;
        repeat (5) @(posedge rx_clk_in);
        rx_reset_in <= 1'b0;

        check_counters();

        // Unicast and broadcast, alternating
        for (int i = 0; i < 24; i++)
            send_frame(make_frame((i % 2) == 1, host_mac, host_ip), 1'b0);
        check_counters();

        // One cause per frame, then two causes at once
        f = make_frame(1'b0, host_mac, host_ip);
        f.eth.dest_mac = f.eth.dest_mac ^ 48'h1;
        send_frame(f, 1'b0);
        f = make_frame(1'b1, host_mac, host_ip);
        f.ip.dest_ip = f.ip.dest_ip ^ 32'h100;
        send_frame(f, 1'b0);
        f = make_frame(1'b0, host_mac, host_ip);
        f.ip.protocol = 8'd6;
        send_frame(f, 1'b0);
        f = make_frame(1'b0, host_mac, host_ip);
        f.ip.version = 4'd6;
        send_frame(f, 1'b0);
        f = make_frame(1'b0, host_mac, host_ip);
        f.eth.dest_mac = 48'h00_11_22_33_44_55;
        f.ip.protocol = 8'd1;
        send_frame(f, 1'b0);
        check_counters();

        // Length mismatch, four beats, short frame
        f = make_frame(1'b0, host_mac, host_ip);
        f.udp.length = f.udp.length + 16'd1;
        send_frame(f, 1'b0);
        f = make_frame(1'b0, host_mac, host_ip);
        f.pay_len = 8'(MAX_PAYLOAD_BYTES);
        f.udp.length = 16'(UDP_HDR_BYTES + MAX_PAYLOAD_BYTES);
        f.extra_beat = 1'b1;
        send_frame(f, 1'b0);
        send_short();
        check_counters();

        // Hold: four frames buffered, two lost to overflow
        @(posedge rx_clk_in);
        deliver_hold <= 1'b1;
        for (int i = 0; i < 6; i++)
            send_frame(make_frame(1'b0, host_mac, host_ip), i >= 4);
        wait_drops();
        if (exp_q.size() != 4)
            fail_run("a packet was delivered while deliver_hold was high");
        @(posedge rx_clk_in);
        deliver_hold <= 1'b0;
        check_counters();

        $display("Simulation passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+test
source/udp_rx_pkg.sv
source/rx_frame_parser.sv
source/rx_packet_fifo.sv
source/udp_packet_filter.sv
source/rx_drop_counters.sv
source/udp_rx_top.sv
test/udp_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UDP receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f tb.f --top-module udp_rx_tb \
    -Mdir obj_dir -o udp_rx_sim

# The simulator exits non-zero on a failed check, the log decides the verdict
./obj_dir/udp_rx_sim 2>&1 | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "RESULT: PASS"
else
    echo "RESULT: FAIL"
    exit 1
fi
